// ==== dcache.f ====
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
dcache.sv
dcache_sva.sv
dcache_tb.sv

// ==== dcache.sv ====
`timescale 1ns/1ps

module dcache
    import dcache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // cpu side
    input  logic         req_valid,
    input  mem_op_t      req_op,
    input  logic [31:0]  req_addr,
    input  word_t        req_wdata,
    input  strb_t        req_wstrb,
    output logic         addr_ok,
    output logic         data_ok,
    output word_t        rdata,

    // memory side
    output logic         wr_req,
    output logic [31:0]  wr_addr,
    output line_t        wr_data,
    input  logic         wr_rdy,
    output logic         rd_req,
    output logic [31:0]  rd_addr,
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  line_t        ret_data
);

    index_t      lookup_index;
    logic        rd_en;
    logic        hit;
    way_t        hit_way;
    way_t        victim_way;
    logic        victim_dirty;
    tag_t        victim_tag;
    line_t       victim_line;
    word_t       hit_word;

    logic        fill_en;
    way_t        fill_way;
    tag_t        fill_tag;
    line_t       fill_line;
    logic        store_en;
    way_t        store_way;
    logic [1:0]  store_word;
    word_t       store_wdata;
    strb_t       store_wstrb;

    dcache_ctrl ctrl_i (
        .*
    );

    // the held request tag doubles as the compare tag
    dcache_tag_array tags_i (
        .req_tag (fill_tag),
        .*
    );

    dcache_data_array data_i (
        .*
    );

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         req_valid,
    input  mem_op_t      req_op,
    input  logic [31:0]  req_addr,
    input  word_t        req_wdata,
    input  strb_t        req_wstrb,
    output logic         addr_ok,
    output logic         data_ok,
    output word_t        rdata,

    input  logic         hit,
    input  way_t         hit_way,
    input  way_t         victim_way,
    input  logic         victim_dirty,
    input  tag_t         victim_tag,
    input  line_t        victim_line,
    input  word_t        hit_word,

    input  logic         ret_valid,
    input  line_t        ret_data,
    input  logic         wr_rdy,
    input  logic         rd_rdy,
    output logic         wr_req,
    output logic [31:0]  wr_addr,
    output line_t        wr_data,
    output logic         rd_req,
    output logic [31:0]  rd_addr,

    output index_t       lookup_index,
    output logic         rd_en,
    output logic         fill_en,
    output way_t         fill_way,
    output logic         store_en,
    output way_t         store_way,
    output logic [1:0]   store_word,
    output word_t        store_wdata,
    output strb_t        store_wstrb,
    output tag_t         fill_tag,
    output line_t        fill_line
);

    cache_state_t state;
    cache_state_t state_nxt;

    mem_op_t      op_q;
    tag_t         tag_q;
    index_t       index_q;
    logic [1:0]   word_q;
    word_t        wdata_q;
    strb_t        wstrb_q;

    logic         accept;
    logic         lookup_hit;

    assign addr_ok    = (state == ST_IDLE);
    assign accept     = addr_ok && req_valid;
    assign lookup_hit = (state == ST_LOOKUP) && hit;

    // held for the whole miss sequence
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_op;
            tag_q   <= addr_tag(req_addr);
            index_q <= addr_index(req_addr);
            word_q  <= addr_word(req_addr);
            wdata_q <= req_wdata;
            wstrb_q <= req_wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (req_valid) state_nxt = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (hit)               state_nxt = ST_IDLE;
                else if (victim_dirty) state_nxt = ST_WRITEBACK;
                else                   state_nxt = ST_REFILL_REQ;
            end
            ST_WRITEBACK: begin
                if (wr_rdy) state_nxt = ST_REFILL_REQ;
            end
            ST_REFILL_REQ: begin
                if (rd_rdy) state_nxt = ST_REFILL_WAIT;
            end
            ST_REFILL_WAIT: begin
                if (ret_valid) state_nxt = ST_REPLAY;
            end
            ST_REPLAY: state_nxt = ST_LOOKUP;   // re-read after the fill
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= lookup_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit) rdata <= hit_word;   // don't care for stores
    end

    // new index straight from the bus on accept
    assign lookup_index = addr_ok ? addr_index(req_addr) : index_q;
    assign rd_en        = accept || (state == ST_REPLAY);

    assign fill_en     = (state == ST_REFILL_WAIT) && ret_valid;
    assign fill_way    = victim_way;
    assign fill_tag    = tag_q;
    assign fill_line   = ret_data;

    assign store_en    = lookup_hit && (op_q == OP_STORE);
    assign store_way   = hit_way;
    assign store_word  = word_q;
    assign store_wdata = wdata_q;
    assign store_wstrb = wstrb_q;

    assign wr_req  = (state == ST_WRITEBACK);
    assign wr_addr = line_addr(victim_tag, index_q);
    assign wr_data = victim_line;
    assign rd_req  = (state == ST_REFILL_REQ);
    assign rd_addr = line_addr(tag_q, index_q);

endmodule

// ==== dcache_data_array.sv ====
`timescale 1ns/1ps

module dcache_data_array
    import dcache_pkg::*;
(
    input  logic        clk,

    input  index_t      lookup_index,
    input  logic        rd_en,

    input  logic        fill_en,
    input  way_t        fill_way,
    input  line_t       fill_line,

    input  logic        store_en,
    input  way_t        store_way,
    input  logic [1:0]  store_word,    // also picks the load word
    input  word_t       store_wdata,
    input  strb_t       store_wstrb,

    input  way_t        hit_way,
    input  way_t        victim_way,
    output word_t       hit_word,
    output line_t       victim_line
);

    line_t line_mem [NUM_WAYS][NUM_SETS];
    line_t line_rd  [NUM_WAYS];

    line_t merged;
    line_t hit_line;

    // old line comes from the lookup read, still held in line_rd
    always_comb begin
        merged = line_rd[store_way];
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (store_wstrb[b]) begin
                merged[store_word * WORD_W + b * 8 +: 8] = store_wdata[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill_en && (fill_way == way_t'(w))) begin
                line_mem[w][lookup_index] <= fill_line;
            end else if (store_en && (store_way == way_t'(w))) begin
                line_mem[w][lookup_index] <= merged;
            end
            if (rd_en) begin
                line_rd[w] <= line_mem[w][lookup_index];
            end
        end
    end

    assign hit_line    = line_rd[hit_way];
    assign hit_word    = hit_line[store_word * WORD_W +: WORD_W];
    assign victim_line = line_rd[victim_way];   // write-back payload

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int NUM_SETS       = 256;
    localparam int NUM_WAYS       = 2;

    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [OFFSET_W-1:0]   offset_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LINE_W-1:0]     line_t;    // word 0 in the low bits
    typedef logic [WORD_W/8-1:0]   strb_t;
    typedef logic                  way_t;

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } mem_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL_WAIT,
        ST_REPLAY
    } cache_state_t;

    function automatic tag_t addr_tag(input logic [31:0] addr);
        return addr[31 -: TAG_W];
    endfunction

    function automatic index_t addr_index(input logic [31:0] addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    // word within the line, byte bits dropped
    function automatic logic [1:0] addr_word(input logic [31:0] addr);
        return addr[OFFSET_W-1:2];
    endfunction

    function automatic logic [31:0] line_addr(input tag_t tag, input index_t index);
        return {tag, index, {OFFSET_W{1'b0}}};
    endfunction

endpackage

// ==== dcache_sva.sv ====
`timescale 1ns/1ps

module dcache_sva
    import dcache_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          addr_ok,
    input  logic          data_ok,
    input  logic          wr_req,
    input  logic          wr_rdy,
    input  logic          rd_req,
    input  logic          rd_rdy
);

    // a completion always reopens the cpu port
    strobe_overlap: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> addr_ok)
        else $error("data_ok without addr_ok back high");

    wr_req_held: assert property (@(posedge clk) disable iff (reset)
        (wr_req && !wr_rdy) |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

    rd_req_held: assert property (@(posedge clk) disable iff (reset)
        (rd_req && !rd_rdy) |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    data_ok_pulse: assert property (@(posedge clk) disable iff (reset)
        data_ok |=> !data_ok)
        else $error("data_ok held longer than one cycle");

endmodule

bind dcache_ctrl dcache_sva sva_i (.*);

// ==== dcache_tag_array.sv ====
`timescale 1ns/1ps

module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    input  index_t  lookup_index,
    input  logic    rd_en,
    input  tag_t    req_tag,

    input  logic    fill_en,
    input  way_t    fill_way,
    input  tag_t    fill_tag,
    input  logic    store_en,
    input  way_t    store_way,

    output logic    hit,
    output way_t    hit_way,
    output way_t    victim_way,
    output logic    victim_dirty,
    output tag_t    victim_tag
);

    tag_t tag_mem [NUM_WAYS][NUM_SETS];
    tag_t tag_rd  [NUM_WAYS];
    index_t idx_q;

    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]               victim_q;   // next way to replace

    logic [NUM_WAYS-1:0] way_hit;

    // tag rams, synchronous read
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill_en && (fill_way == way_t'(w))) begin
                tag_mem[w][lookup_index] <= fill_tag;
            end
            if (rd_en) begin
                tag_rd[w] <= tag_mem[w][lookup_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) idx_q <= lookup_index;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            victim_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_way][lookup_index] <= 1'b1;
            dirty_q[fill_way][lookup_index] <= 1'b0;
            victim_q[lookup_index]          <= ~victim_q[lookup_index];
        end else if (store_en) begin
            dirty_q[store_way][lookup_index] <= 1'b1;
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[w][idx_q] && (tag_rd[w] == req_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // flops read live so a store hit shows up before the next miss
    assign victim_way   = victim_q[idx_q];
    assign victim_dirty = valid_q[victim_way][idx_q] && dirty_q[victim_way][idx_q];
    assign victim_tag   = tag_rd[victim_way];

endmodule

// ==== dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int    TIMEOUT  = 200;
    localparam word_t FILL_KEY = 32'hc3a5_5a3c;   // unwritten memory pattern

    logic         clk = 1'b0;
    logic         reset, req_valid, addr_ok, data_ok, wr_req, rd_req;
    mem_op_t      req_op;
    logic [31:0]  req_addr, wr_addr, rd_addr;
    word_t        req_wdata, rdata;
    strb_t        req_wstrb;
    line_t        wr_data;
    logic         wr_rdy = 1'b0, rd_rdy = 1'b0, ret_valid = 1'b0;
    line_t        ret_data = '0;

    word_t        mem [logic [29:0]];      // backing memory, word address
    word_t        shadow [logic [29:0]];   // what the cpu has stored
    tag_t         m_tag [2][256];
    logic         m_valid [2][256];
    logic         m_dirty [2][256];
    logic         m_victim [256];
    line_t        m_line [2][256];

    logic [15:0]  lfsr = 16'd78;
    int           errors = 0, checks = 0, done_count = 0, dok_count = 0;
    int           wb_count = 0, rd_count = 0, rd_wait = 0, wr_wait = 0, ret_wait = 0;
    logic         ret_pending = 1'b0;
    logic [31:0]  last_rd_addr, last_wr_addr;
    line_t        last_wr_data;

    dcache dut_i (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    function automatic word_t cold_word(input logic [29:0] wa);
        return {2'b00, wa} ^ FILL_KEY;
    endfunction

    function automatic word_t mem_word(input logic [29:0] wa);
        return mem.exists(wa) ? mem[wa] : cold_word(wa);
    endfunction

    function automatic word_t model_word(input logic [29:0] wa);
        return shadow.exists(wa) ? shadow[wa] : cold_word(wa);
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("%0t error: %s", $time, msg);
    endtask

    task automatic abort_run(input string msg);
        $display("%0t timeout: %s", $time, msg);
        $display("Test failed");
        $finish;
    endtask

    // memory side, random ready and return delays of 0 to 3 cycles
    always @(posedge clk) begin
        wr_rdy    <= 1'b0;
        rd_rdy    <= 1'b0;
        ret_valid <= 1'b0;
        if (wr_req && wr_rdy) begin
            for (int i = 0; i < 4; i++) mem[{wr_addr[31:4], 2'(i)}] = wr_data[i*32 +: 32];
            last_wr_addr = wr_addr;
            last_wr_data = wr_data;
            wb_count++;
            wr_wait = rand_bits(2);
        end else if (wr_req) begin
            if (wr_wait == 0) wr_rdy <= 1'b1;
            else wr_wait--;
        end
        if (rd_req && rd_rdy) begin
            last_rd_addr = rd_addr;
            rd_count++;
            ret_pending = 1'b1;
            ret_wait = rand_bits(2);
            rd_wait = rand_bits(2);
        end else if (rd_req) begin
            if (rd_wait == 0) rd_rdy <= 1'b1;
            else rd_wait--;
        end else if (ret_pending) begin
            if (ret_wait == 0) begin
                ret_valid <= 1'b1;
                for (int i = 0; i < 4; i++) begin
                    ret_data[i*32 +: 32] <= mem_word({last_rd_addr[31:4], 2'(i)});
                end
                ret_pending = 1'b0;
            end else begin
                ret_wait--;
            end
        end
    end

    always @(posedge clk) begin
        if (data_ok) dok_count <= dok_count + 1;
    end

    // model step first, then one request on the bus
    task automatic access(input mem_op_t op, input logic [31:0] addr,
                          input word_t wdata, input strb_t wstrb);
        tag_t         t;
        index_t       ix;
        int           wi, way, lat, wb0, rd0;
        logic         miss, need_wb;
        logic [31:0]  wb_addr;
        line_t        wb_line;
        word_t        w;
        t = addr[31:12];
        ix = addr[11:4];
        wi = addr[3:2];
        way = -1;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[i][ix] && m_tag[i][ix] == t) way = i;
        end
        miss = (way < 0);
        need_wb = 1'b0;
        if (miss) begin
            way = m_victim[ix];
            need_wb = m_valid[way][ix] && m_dirty[way][ix];
            wb_addr = {m_tag[way][ix], ix, 4'h0};
            wb_line = m_line[way][ix];
            for (int i = 0; i < 4; i++) begin
                m_line[way][ix][i*32 +: 32] = model_word({addr[31:4], 2'(i)});
            end
            m_tag[way][ix] = t;
            m_valid[way][ix] = 1'b1;
            m_dirty[way][ix] = 1'b0;
            m_victim[ix] = ~m_victim[ix];
        end
        w = m_line[way][ix][wi*32 +: 32];
        if (op == OP_STORE) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) w[b*8 +: 8] = wdata[b*8 +: 8];
            end
            m_line[way][ix][wi*32 +: 32] = w;
            m_dirty[way][ix] = 1'b1;
            shadow[addr[31:2]] = w;
        end
        wb0 = wb_count;
        rd0 = rd_count;
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_wstrb <= wstrb;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!addr_ok && lat < TIMEOUT);
        if (!addr_ok) abort_run("request never accepted");
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_ok && lat < TIMEOUT);
        if (!data_ok) abort_run("no data_ok for an accepted request");
        done_count++;
        if (op == OP_LOAD) check_word("rdata", rdata, w);
        if (!miss && lat != 2) note_error($sformatf("hit at %h took %0d cycles", addr, lat));
        if (miss) begin
            if (rd_count != rd0 + 1) note_error("miss without exactly one refill read");
            check_addr("rd_addr", last_rd_addr, {addr[31:4], 4'h0});
        end else if (rd_count != rd0) begin
            note_error("refill read issued on a hit");
        end
        if (need_wb) begin
            if (wb_count != wb0 + 1) note_error("dirty victim was not written back");
            check_addr("wr_addr", last_wr_addr, wb_addr);
            check_line("wr_data", last_wr_data, wb_line);
        end else if (wb_count != wb0) begin
            note_error("write-back of a clean or valid-less line");
        end
    endtask

    task automatic end_test(input string name, input int e0);
        repeat (2) @(posedge clk);
        if (dok_count != done_count) note_error("data_ok count differs from completed requests");
        $display("%-32s %s", name, (errors == e0) ? "ok" : "errors");
    endtask

    initial begin
        int           e0;
        logic [31:0]  a;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_LOAD;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        for (int s = 0; s < 256; s++) begin
            m_victim[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            access(OP_LOAD, {20'h00012, 8'(16 + i), 2'(rand_bits(2)), 2'b00}, '0, '0);
        end
        end_test("cold load misses", e0);

        e0 = errors;
        access(OP_LOAD, {20'h00012, 8'd16, 4'hc}, '0, '0);
        end_test("load hit after fill", e0);

        e0 = errors;
        a = {20'h00012, 8'd17, 4'h4};
        access(OP_STORE, a, rand_bits(32), 4'(rand_bits(4)));
        access(OP_LOAD, a, '0, '0);
        end_test("store hit then load", e0);

        e0 = errors;
        access(OP_LOAD, {20'h0a000, 8'h40, 4'h0}, '0, '0);
        access(OP_LOAD, {20'h0b000, 8'h40, 4'h4}, '0, '0);
        access(OP_LOAD, {20'h0a000, 8'h40, 4'h8}, '0, '0);
        access(OP_LOAD, {20'h0b000, 8'h40, 4'hc}, '0, '0);
        access(OP_STORE, {20'h0a000, 8'h40, 4'h4}, rand_bits(32), 4'hf);
        access(OP_LOAD, {20'h0c000, 8'h40, 4'h0}, '0, '0);    // evicts dirty a
        access(OP_LOAD, {20'h0a000, 8'h40, 4'h4}, '0, '0);    // evicts clean b
        end_test("shared index and eviction", e0);

        e0 = errors;
        repeat (300) begin
            a = {20'h00100 + 20'(rand_bits(2)), 8'(rand_bits(2)), 2'(rand_bits(2)), 2'b00};
            if (rand_bits(1)) access(OP_STORE, a, rand_bits(32), 4'(rand_bits(4)));
            else access(OP_LOAD, a, '0, '0);
        end
        // two fresh tags per set push every dirty line out
        foreach (shadow[k]) begin
            access(OP_LOAD, {20'hfff00, k[9:2], 4'h0}, '0, '0);
            access(OP_LOAD, {20'hfff01, k[9:2], 4'h0}, '0, '0);
        end
        foreach (shadow[k]) begin
            check_word($sformatf("mem[%h]", {k, 2'b00}), mem_word(k), shadow[k]);
        end
        end_test("random mix and write-back", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
